// ==== src/isa_pkg.sv ====
package isa_pkg;

    // barrier view of an instruction word
    typedef struct packed {
        logic [16:0] op;
        logic [14:0] hint;
    } bar_view_t;

    // csrrd / csrwr / csrxchg view
    typedef struct packed {
        logic [7:0]  op;
        logic [13:0] csr_num;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } csr_view_t;

    typedef union packed {
        bar_view_t bar;
        csr_view_t csr;
    } inst_word_u;

    // ibar hint, top 17 bits
    localparam logic [16:0] OP_IBAR = 17'h070e5;

    // csr access, top 8 bits
    localparam logic [7:0] OP_CSR = 8'h04;

    // rj of 0 is a plain csr read
    localparam logic [4:0] CSR_RJ_RD = 5'd0;

    // andi r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

endpackage

// ==== src/fe_pkg.sv ====
package fe_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] PC_RESET = 32'h1c00_0000;

    // byte spans of one word and one bundle
    localparam logic [XLEN-1:0] INST_BYTES   = 32'd4;
    localparam logic [XLEN-1:0] BUNDLE_BYTES = 32'd8;

    // one fetched pair, pc_next is pc + 8 unless slot 1 was killed
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     pc_next;
        isa_pkg::inst_word_u inst0;
        isa_pkg::inst_word_u inst1;
    } fetch_bundle_t;

    typedef enum logic [1:0] {
        BAR_NONE = 2'd0,
        BAR_IBAR = 2'd1,
        BAR_CSR  = 2'd2
    } bar_class_e;

    // slot bit 0 is inst0, bit 1 is inst1
    typedef struct packed {
        logic [1:0] slot;
        bar_class_e cls;
    } bar_info_t;

    typedef struct packed {
        logic [XLEN-1:0]     pc;
        isa_pkg::inst_word_u inst;
    } issue_t;

endpackage

// ==== src/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [fe_pkg::XLEN-1:0] flush_pc,
    input  logic                    fetch_kill,
    input  logic                    redirect_valid,
    input  logic [fe_pkg::XLEN-1:0] redirect_pc,
    output logic                    imem_req_valid,
    output logic [fe_pkg::XLEN-1:0] imem_req_pc,
    input  logic                    imem_req_ready,
    input  logic                    imem_rsp_valid,
    input  logic [31:0]             imem_rsp_inst0,
    input  logic [31:0]             imem_rsp_inst1,
    output logic                    bundle_valid,
    output fe_pkg::fetch_bundle_t   bundle,
    input  logic                    bundle_ready
);

    logic [fe_pkg::XLEN-1:0] pc;
    logic [fe_pkg::XLEN-1:0] req_pc;
    logic                    run;
    logic                    req_out;
    logic                    discard;
    logic                    req_fire;
    logic                    rsp_take;

    // one request in flight, and only into an empty bundle register
    assign imem_req_valid = run && !req_out && !bundle_valid && !fetch_kill && !flush;
    assign imem_req_pc    = pc;
    assign req_fire       = imem_req_valid && imem_req_ready;

    // responses during a kill are younger than the barrier
    assign rsp_take = imem_rsp_valid && !discard && !fetch_kill && !flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run          <= 1'b0;
            pc           <= fe_pkg::PC_RESET;
            req_out      <= 1'b0;
            discard      <= 1'b0;
            bundle_valid <= 1'b0;
        end else begin
            run <= 1'b1;

            if (flush) begin
                pc <= flush_pc;
            end else if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (req_fire) begin
                pc <= pc + fe_pkg::BUNDLE_BYTES;
            end

            if (req_fire) begin
                req_out <= 1'b1;
            end else if (imem_rsp_valid) begin
                req_out <= 1'b0;
            end

            // the response still in flight belongs to the old path
            if (imem_rsp_valid) begin
                discard <= 1'b0;
            end else if ((flush || redirect_valid) && req_out) begin
                discard <= 1'b1;
            end

            if (flush || fetch_kill) begin
                bundle_valid <= 1'b0;
            end else if (rsp_take) begin
                bundle_valid <= 1'b1;
            end else if (bundle_ready) begin
                bundle_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pc <= pc;
        end
        if (rsp_take) begin
            bundle.pc      <= req_pc;
            bundle.pc_next <= req_pc + fe_pkg::BUNDLE_BYTES;
            bundle.inst0   <= imem_rsp_inst0;
            bundle.inst1   <= imem_rsp_inst1;
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        req_fire |=> !imem_req_valid throughout imem_rsp_valid[->1]);

endmodule

// ==== src/fetch_predecode.sv ====
`timescale 1ns/1ps

module fetch_predecode (
    input  fe_pkg::fetch_bundle_t bundle,
    output fe_pkg::bar_info_t     bar_info
);

    isa_pkg::inst_word_u slot_inst [2];
    logic [1:0]          is_ibar;
    logic [1:0]          is_csr;

    assign slot_inst[0] = bundle.inst0;
    assign slot_inst[1] = bundle.inst1;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            is_ibar[i] = slot_inst[i].bar.op == isa_pkg::OP_IBAR;
            // csrwr and csrxchg both write
            is_csr[i]  = slot_inst[i].csr.op == isa_pkg::OP_CSR &&
                         slot_inst[i].csr.rj != isa_pkg::CSR_RJ_RD;
        end
    end

    // oldest barrier wins
    always_comb begin
        bar_info.slot = 2'b00;
        bar_info.cls  = fe_pkg::BAR_NONE;
        if (is_ibar[0] || is_csr[0]) begin
            bar_info.slot = 2'b01;
            if (is_ibar[0]) begin
                bar_info.cls = fe_pkg::BAR_IBAR;
            end else begin
                bar_info.cls = fe_pkg::BAR_CSR;
            end
        end else if (is_ibar[1] || is_csr[1]) begin
            bar_info.slot = 2'b10;
            if (is_ibar[1]) begin
                bar_info.cls = fe_pkg::BAR_IBAR;
            end else begin
                bar_info.cls = fe_pkg::BAR_CSR;
            end
        end
    end

endmodule

// ==== src/fetch_stage_buf.sv ====
`timescale 1ns/1ps

module fetch_stage_buf (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    bundle_valid,
    input  fe_pkg::fetch_bundle_t   bundle,
    output logic                    bundle_ready,
    input  fe_pkg::bar_info_t       bar_info,
    output logic                    stage_valid,
    output fe_pkg::fetch_bundle_t   stage_bundle,
    input  logic                    stage_ready,
    input  logic                    bar_ack,
    input  logic                    cache_idle,
    input  logic                    csr_done,
    output logic                    fetch_kill,
    output logic                    redirect_valid,
    output logic [fe_pkg::XLEN-1:0] redirect_pc
);

    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_WAIT_ACK   = 2'd1,
        ST_WAIT_CACHE = 2'd2,
        ST_WAIT_CSR   = 2'd3
    } bar_state_e;

    bar_state_e              state;
    fe_pkg::bar_class_e      cls_q;
    logic [fe_pkg::XLEN-1:0] redirect_pc_q;
    logic                    ready_q;
    logic                    skid_valid;
    fe_pkg::fetch_bundle_t   skid_bundle;
    fe_pkg::fetch_bundle_t   in_bundle;
    logic                    accept;
    logic                    stage_free;
    logic                    skid_wr;
    logic                    bar_hit;

    // ready lags stage_ready by a cycle, the skid slot covers the gap
    assign bundle_ready = ready_q && !skid_valid && state == ST_IDLE;
    assign accept       = bundle_valid && bundle_ready;
    assign stage_free   = !stage_valid || stage_ready;
    assign skid_wr      = accept && !stage_free;
    assign bar_hit      = accept && bar_info.cls != fe_pkg::BAR_NONE;

    assign fetch_kill     = state != ST_IDLE;
    assign redirect_valid = (state == ST_WAIT_CACHE && cache_idle) ||
                            (state == ST_WAIT_CSR && csr_done);
    assign redirect_pc    = redirect_pc_q;

    // slot-0 barrier drops inst1 and shrinks the bundle span to one word
    always_comb begin
        in_bundle = bundle;
        if (bar_info.slot[0]) begin
            in_bundle.inst1   = isa_pkg::INST_NOP;
            in_bundle.pc_next = bundle.pc + fe_pkg::INST_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q     <= 1'b0;
            stage_valid <= 1'b0;
            skid_valid  <= 1'b0;
            state       <= ST_IDLE;
            cls_q       <= fe_pkg::BAR_NONE;
        end else begin
            ready_q <= stage_ready;
            if (flush) begin
                stage_valid <= 1'b0;
                skid_valid  <= 1'b0;
                state       <= ST_IDLE;
            end else begin
                if (stage_free) begin
                    stage_valid <= skid_valid || accept;
                    skid_valid  <= 1'b0;
                end else if (skid_wr) begin
                    skid_valid <= 1'b1;
                end

                case (state)
                    ST_IDLE: begin
                        if (bar_hit) begin
                            state <= ST_WAIT_ACK;
                            cls_q <= bar_info.cls;
                        end
                    end
                    ST_WAIT_ACK: begin
                        if (bar_ack) begin
                            if (cls_q == fe_pkg::BAR_IBAR) begin
                                state <= ST_WAIT_CACHE;
                            end else begin
                                state <= ST_WAIT_CSR;
                            end
                        end
                    end
                    ST_WAIT_CACHE: begin
                        if (cache_idle) begin
                            state <= ST_IDLE;
                        end
                    end
                    ST_WAIT_CSR: begin
                        if (csr_done) begin
                            state <= ST_IDLE;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage_free) begin
            if (skid_valid) begin
                stage_bundle <= skid_bundle;
            end else if (accept) begin
                stage_bundle <= in_bundle;
            end
        end else if (skid_wr) begin
            skid_bundle <= in_bundle;
        end
        // resume right after the barrier
        if (bar_hit) begin
            if (bar_info.slot[0]) begin
                redirect_pc_q <= bundle.pc + fe_pkg::INST_BYTES;
            end else begin
                redirect_pc_q <= bundle.pc + fe_pkg::BUNDLE_BYTES;
            end
        end
    end

    a_skid_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        skid_wr |-> !skid_valid);

    // the exit must match the class captured with the barrier
    a_redirect_on_exit: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |->
            (cls_q == fe_pkg::BAR_IBAR && cache_idle) ||
            (cls_q == fe_pkg::BAR_CSR && csr_done));

endmodule

// ==== src/inst_issue_queue.sv ====
`timescale 1ns/1ps

module inst_issue_queue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  stage_valid,
    input  fe_pkg::fetch_bundle_t stage_bundle,
    output logic                  stage_ready,
    output logic                  issue_valid,
    output fe_pkg::issue_t        issue,
    input  logic                  issue_ready
);

    fe_pkg::fetch_bundle_t q_bundle;
    logic                  q_valid;
    logic                  slot_ptr;
    logic                  has_second;
    logic                  last_slot;
    logic                  issue_fire;
    logic                  stage_fire;
    logic                  in_second;

    assign last_slot   = slot_ptr || !has_second;
    assign issue_valid = q_valid;
    assign issue_fire  = q_valid && issue_ready;
    assign stage_ready = !q_valid || (issue_ready && last_slot);
    assign stage_fire  = stage_valid && stage_ready;

    // killed slot 1 shows as a one-word span with a nop
    assign in_second = !((stage_bundle.pc_next - stage_bundle.pc == fe_pkg::INST_BYTES) &&
                         stage_bundle.inst1 == isa_pkg::INST_NOP);

    always_comb begin
        issue.pc   = q_bundle.pc;
        issue.inst = q_bundle.inst0;
        if (slot_ptr) begin
            issue.pc   = q_bundle.pc + fe_pkg::INST_BYTES;
            issue.inst = q_bundle.inst1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_valid    <= 1'b0;
            slot_ptr   <= 1'b0;
            has_second <= 1'b0;
            q_bundle   <= '0;
        end else if (flush) begin
            q_valid  <= 1'b0;
            slot_ptr <= 1'b0;
        end else if (stage_fire) begin
            q_valid    <= 1'b1;
            slot_ptr   <= 1'b0;
            has_second <= in_second;
            q_bundle   <= stage_bundle;
        end else if (issue_fire) begin
            if (last_slot) begin
                q_valid <= 1'b0;
            end else begin
                slot_ptr <= 1'b1;
            end
        end
    end

    a_issue_stable: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready && !flush |=> issue_valid && $stable(issue));

endmodule

// ==== src/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [fe_pkg::XLEN-1:0] flush_pc,
    output logic                    imem_req_valid,
    output logic [fe_pkg::XLEN-1:0] imem_req_pc,
    input  logic                    imem_req_ready,
    input  logic                    imem_rsp_valid,
    input  logic [31:0]             imem_rsp_inst0,
    input  logic [31:0]             imem_rsp_inst1,
    output logic                    issue_valid,
    output fe_pkg::issue_t          issue,
    input  logic                    issue_ready,
    input  logic                    bar_ack,
    input  logic                    cache_idle,
    input  logic                    csr_done
);

    logic                    bundle_valid;
    fe_pkg::fetch_bundle_t   bundle;
    logic                    bundle_ready;
    fe_pkg::bar_info_t       bar_info;
    logic                    stage_valid;
    fe_pkg::fetch_bundle_t   stage_bundle;
    logic                    stage_ready;
    logic                    fetch_kill;
    logic                    redirect_valid;
    logic [fe_pkg::XLEN-1:0] redirect_pc;

    fetch_pc_gen u_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .fetch_kill     (fetch_kill),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_req_valid (imem_req_valid),
        .imem_req_pc    (imem_req_pc),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_inst0 (imem_rsp_inst0),
        .imem_rsp_inst1 (imem_rsp_inst1),
        .bundle_valid   (bundle_valid),
        .bundle         (bundle),
        .bundle_ready   (bundle_ready)
    );

    fetch_predecode u_predecode (
        .bundle   (bundle),
        .bar_info (bar_info)
    );

    fetch_stage_buf u_stage_buf (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .bundle_valid   (bundle_valid),
        .bundle         (bundle),
        .bundle_ready   (bundle_ready),
        .bar_info       (bar_info),
        .stage_valid    (stage_valid),
        .stage_bundle   (stage_bundle),
        .stage_ready    (stage_ready),
        .bar_ack        (bar_ack),
        .cache_idle     (cache_idle),
        .csr_done       (csr_done),
        .fetch_kill     (fetch_kill),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    inst_issue_queue u_issue_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .stage_valid  (stage_valid),
        .stage_bundle (stage_bundle),
        .stage_ready  (stage_ready),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready)
    );

endmodule

// ==== testbench/tb_frontend.sv ====
`timescale 1ns/1ps

module tb_frontend;

    localparam int  N_INST     = 1500;
    localparam int  N_CALM     = 24;
    localparam int  N_FLUSH_ON = 200;
    localparam int  RST_CYCLES = 16;
    localparam time CLK_PERIOD = 40;

    logic           clk;
    logic           rst_n;
    logic           flush;
    logic [31:0]    flush_pc;
    logic           imem_req_valid;
    logic [31:0]    imem_req_pc;
    logic           imem_req_ready;
    logic           imem_rsp_valid;
    logic [31:0]    imem_rsp_inst0;
    logic [31:0]    imem_rsp_inst1;
    logic           issue_valid;
    fe_pkg::issue_t issue;
    logic           issue_ready;
    logic           bar_ack;
    logic           cache_idle;
    logic           csr_done;

    integer      seed;
    logic [31:0] mem [256];
    logic [31:0] exp_pc;
    logic [31:0] exp_req_pc;
    logic        align;
    logic        rsp_busy;
    logic [31:0] rsp_pc;
    int          rsp_wait;
    int          bar_state;
    int          bar_wait;
    logic        bar_is_csr;
    logic        after_flush;
    int          rst_seen;
    int          n_issued;
    int          n_flush;
    int          n_bar [2][2];
    int          val_errs;
    int          oth_errs;

    frontend_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .imem_req_valid (imem_req_valid),
        .imem_req_pc    (imem_req_pc),
        .imem_req_ready (imem_req_ready),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_inst0 (imem_rsp_inst0),
        .imem_rsp_inst1 (imem_rsp_inst1),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .bar_ack        (bar_ack),
        .cache_idle     (cache_idle),
        .csr_done       (csr_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return mem[addr[9:2]];
    endfunction

    function automatic logic is_ibar(input logic [31:0] w);
        return w[31:15] == isa_pkg::OP_IBAR;
    endfunction

    // rj of zero is a plain read
    function automatic logic is_csr_wr(input logic [31:0] w);
        return w[31:24] == isa_pkg::OP_CSR && w[9:5] != 5'd0;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            val_errs++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic report_fault(input string what);
        oth_errs++;
        $display("%0t %s", $time, what);
    endtask

    task automatic fill_memory();
        logic [31:0] w;
        for (int i = 0; i < 256; i++) begin
            w = $random(seed);
            while (is_ibar(w) || w[31:24] == isa_pkg::OP_CSR) begin
                w = $random(seed);
            end
            // about one barrier in twenty, none in the calm start
            if (i >= 32 && rand_below(20) == 0) begin
                if (rand_below(2) == 0) begin
                    w[31:15] = isa_pkg::OP_IBAR;
                end else begin
                    w[31:24] = isa_pkg::OP_CSR;
                    w[9:5]   = 5'd1 + 5'(rand_below(31));
                end
            end
            mem[i] = w;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            // outputs are known after the first reset edge
            if (rst_seen > 0) begin
                check_eq("issue_valid", 32'd0, {31'd0, issue_valid});
                check_eq("imem_req_valid", 32'd0, {31'd0, imem_req_valid});
                check_eq("issue.pc", 32'd0, issue.pc);
                check_eq("issue.inst", 32'd0, issue.inst);
            end
            rst_seen++;
        end else begin
            bar_ack        <= 1'b0;
            cache_idle     <= 1'b0;
            csr_done       <= 1'b0;
            imem_rsp_valid <= 1'b0;

            // instruction memory
            if (rsp_busy) begin
                if (rsp_wait == 0) begin
                    imem_rsp_valid <= 1'b1;
                    imem_rsp_inst0 <= word_at(rsp_pc);
                    imem_rsp_inst1 <= word_at(rsp_pc + 32'd4);
                    rsp_busy = 1'b0;
                end else begin
                    rsp_wait--;
                end
            end else if (imem_req_valid && imem_req_ready) begin
                // fetch walks in bundle steps from the last redirect or flush
                check_eq("imem_req_pc", exp_req_pc, imem_req_pc);
                exp_req_pc = exp_req_pc + 32'd8;
                rsp_busy = 1'b1;
                rsp_pc   = imem_req_pc;
                rsp_wait = (n_issued < N_CALM) ? 0 : rand_below(5);
            end

            if (after_flush) begin
                check_eq("issue_valid", 32'd0, {31'd0, issue_valid});
                after_flush = 1'b0;
            end

            if (flush) begin
                exp_pc      = flush_pc;
                exp_req_pc  = flush_pc;
                align       = flush_pc[2];
                after_flush = 1'b1;
                n_flush++;
            end else if (issue_valid && issue_ready) begin
                if (bar_state != 0) begin
                    report_fault("instruction issued while a barrier was still waiting");
                end
                check_eq("issue.pc", exp_pc, issue.pc);
                check_eq("issue.inst", word_at(exp_pc), issue.inst);
                if (is_ibar(word_at(exp_pc)) || is_csr_wr(word_at(exp_pc))) begin
                    bar_is_csr = is_csr_wr(word_at(exp_pc));
                    n_bar[exp_pc[2] ^ align][bar_is_csr]++;
                    // refetch starts one word on, which sets the bundle alignment
                    align      = ~exp_pc[2];
                    exp_req_pc = exp_pc + 32'd4;
                    bar_state  = 1;
                    bar_wait   = rand_below(6);
                end
                exp_pc = exp_pc + 32'd4;
                n_issued++;
            end

            // backend side of the barrier
            if (bar_state == 1) begin
                if (bar_wait == 0) begin
                    bar_ack  <= 1'b1;
                    bar_state = 2;
                    bar_wait  = rand_below(6);
                end else begin
                    bar_wait--;
                end
            end else if (bar_state == 2) begin
                if (bar_wait == 0) begin
                    if (bar_is_csr) begin
                        csr_done <= 1'b1;
                    end else begin
                        cache_idle <= 1'b1;
                    end
                    bar_state = 0;
                end else begin
                    bar_wait--;
                end
            end

            if (n_issued >= N_FLUSH_ON && !flush && bar_state == 0 &&
                rand_below(60) == 0) begin
                flush       <= 1'b1;
                flush_pc    <= {fe_pkg::PC_RESET[31:10], 8'(rand_below(256)), 2'b00};
                issue_ready <= 1'b0;
            end else begin
                flush       <= 1'b0;
                issue_ready <= (n_issued < N_CALM) || rand_below(3) != 0;
            end
            imem_req_ready <= (n_issued < N_CALM) || rand_below(4) != 0;
        end
    end

    initial begin
        seed           = 32'h3d69_a61e;
        clk            = 1'b0;
        rst_n          = 1'b0;
        flush          = 1'b0;
        flush_pc       = 32'd0;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_inst0 = 32'd0;
        imem_rsp_inst1 = 32'd0;
        issue_ready    = 1'b0;
        bar_ack        = 1'b0;
        cache_idle     = 1'b0;
        csr_done       = 1'b0;
        exp_pc         = fe_pkg::PC_RESET;
        exp_req_pc     = fe_pkg::PC_RESET;
        align          = 1'b0;
        rsp_busy       = 1'b0;
        rsp_pc         = 32'd0;
        rsp_wait       = 0;
        bar_state      = 0;
        bar_wait       = 0;
        bar_is_csr     = 1'b0;
        after_flush    = 1'b0;
        rst_seen       = 0;
        n_issued       = 0;
        n_flush        = 0;
        val_errs       = 0;
        oth_errs       = 0;
        for (int s = 0; s < 2; s++) begin
            for (int c = 0; c < 2; c++) begin
                n_bar[s][c] = 0;
            end
        end
        fill_memory();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait (n_issued >= N_INST);
        if (n_bar[0][0] == 0) begin
            report_fault("no ibar barrier in slot 0 was issued");
        end
        if (n_bar[1][1] == 0) begin
            report_fault("no csr barrier in slot 1 was issued");
        end
        if (n_flush == 0) begin
            report_fault("no external flush was applied");
        end
        $display("value errors %0d, other errors %0d, issued %0d, flushes %0d",
                 val_errs, oth_errs, n_issued, n_flush);
        if (val_errs == 0 && oth_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // worst case of 400 cycles per instruction
    initial begin
        #((RST_CYCLES + 400 * N_INST) * CLK_PERIOD);
        $display("run timed out with %0d of %0d instructions issued", n_issued, N_INST);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== frontend.f ====
src/isa_pkg.sv
src/fe_pkg.sv
src/fetch_pc_gen.sv
src/fetch_predecode.sv
src/fetch_stage_buf.sv
src/inst_issue_queue.sv
src/frontend_top.sv
testbench/tb_frontend.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_frontend
FILELIST = frontend.f
VFLAGS   = --binary --timing --assert -j 0 --top-module $(TOP)
OBJDIR   = obj_dir
SIM_BIN  = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
